//--- rv_decoder.f
+incdir+source
source/rv_decoder_pkg.sv
source/imm_gen.sv
source/op_decode.sv
source/mem_access_fsm.sv
source/rv_decoder.sv
testbench/tb_rv_decoder.sv

//--- source/imm_gen.sv
`include "rv_decoder_consts.svh"

module imm_gen import rv_decoder_pkg::*; (
    input  instr_u            instr_i,
    input  imm_fmt_t          imm_fmt_i,
    output logic [`XLEN-1:0]  imm_val_o
);

    // Immediate assembled from the view that the decoder picked
    always_comb begin
        case (imm_fmt_i)
            IMM_I: begin
                imm_val_o = {{(`XLEN-12){instr_i.i.imm_11_0[11]}},
                             instr_i.i.imm_11_0};
            end
            IMM_S: begin
                // Split field, rejoined before extension
                imm_val_o = {{(`XLEN-12){instr_i.s.imm_11_5[6]}},
                             instr_i.s.imm_11_5,
                             instr_i.s.imm_4_0};
            end
            IMM_B: begin
                imm_val_o = {{(`XLEN-13){instr_i.b.imm_12}},
                             instr_i.b.imm_12,
                             instr_i.b.imm_11,
                             instr_i.b.imm_10_5,
                             instr_i.b.imm_4_1,
                             1'b0};  // Halfword aligned target
            end
            IMM_U: begin
                imm_val_o = {instr_i.u.imm_31_12, 12'b0};  // Upper bits, low part clear
            end
            IMM_J: begin
                imm_val_o = {{(`XLEN-21){instr_i.j.imm_20}},
                             instr_i.j.imm_20,
                             instr_i.j.imm_19_12,
                             instr_i.j.imm_11,
                             instr_i.j.imm_10_1,
                             1'b0};
            end
            default: begin
                imm_val_o = '0;  // R-type and unknown words
            end
        endcase
    end

endmodule

//--- source/mem_access_fsm.sv
module mem_access_fsm (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  is_load_store_i,
    input  logic  mem_w_i,
    input  logic  mem_gnt_i,
    input  logic  mem_rvalid_i,
    input  logic  load_wait_i,
    output logic  mem_req_o,
    output logic  is_stall_o,
    output logic  load_wait_o
);

    // Request phase lives in IDLE while the access is open
    typedef enum logic {ST_IDLE, ST_WAIT_DATA} state_t;

    state_t state_q;
    state_t state_d;
    logic   access_done;

    // Stores finish on rvalid, loads on the load wait flag
    assign access_done = mem_w_i ? mem_rvalid_i : load_wait_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        mem_req_o   = 1'b0;
        is_stall_o  = 1'b0;
        load_wait_o = 1'b0;
        if (rst_n_i) begin  // Quiet while reset is held
            case (state_q)
                ST_IDLE: begin
                    if (is_load_store_i) begin
                        mem_req_o  = 1'b1;  // Held until granted
                        is_stall_o = 1'b1;
                        if (mem_gnt_i) begin
                            state_d = ST_WAIT_DATA;
                        end
                    end
                end
                ST_WAIT_DATA: begin
                    if (access_done) begin
                        state_d = ST_IDLE;  // Core moves on this cycle
                    end else begin
                        is_stall_o  = 1'b1;
                        load_wait_o = ~mem_w_i;
                    end
                end
                default: state_d = ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/op_decode.sv
`include "rv_decoder_consts.svh"

module op_decode import rv_decoder_pkg::*; (
    input  instr_u    instr_i,
    output ctrl_t     ctrl_o,
    output imm_fmt_t  imm_fmt_o
);

    alu_op_t alu_fn;  // ALU operation from funct3, shared by ALU and IMM groups

    // funct7 bit 5 picks the arithmetic shift for both forms
    always_comb begin
        case (instr_i.r.funct3)
            `F3_ADD_SUB: alu_fn = ALU_ADD;
            `F3_SLL:     alu_fn = ALU_SLL;
            `F3_SLT:     alu_fn = ALU_SLT;
            `F3_SLTU:    alu_fn = ALU_SLTU;
            `F3_XOR:     alu_fn = ALU_XOR;
            `F3_SRL_SRA: alu_fn = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
            `F3_OR:      alu_fn = ALU_OR;
            `F3_AND:     alu_fn = ALU_AND;
            default:     alu_fn = ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl_o    = '0;        // Unknown opcodes keep the all-zero word
        imm_fmt_o = IMM_NONE;

        case (instr_i.r.opcode)
            `OPC_LUI: begin
                ctrl_o.data_origin = ORG_IMM_RS1;  // x0 plus the upper immediate
                ctrl_o.reg_w       = 1'b1;
                ctrl_o.reg_addr    = instr_i.r.rd;
                ctrl_o.r1_addr     = '0;
                imm_fmt_o          = IMM_U;
            end
            `OPC_AUIPC: begin
                ctrl_o.data_origin = ORG_IMM_PC;
                ctrl_o.reg_w       = 1'b1;
                ctrl_o.reg_addr    = instr_i.r.rd;
                imm_fmt_o          = IMM_U;
            end
            `OPC_JAL: begin
                ctrl_o.is_branch   = 1'b1;
                ctrl_o.data_origin = ORG_IMM_PC;  // Target is PC relative
                ctrl_o.data_target = TGT_PC_4;    // Link address to rd
                ctrl_o.reg_w       = 1'b1;
                ctrl_o.reg_addr    = instr_i.r.rd;
                imm_fmt_o          = IMM_J;
            end
            `OPC_JALR: begin
                ctrl_o.is_branch   = 1'b1;
                ctrl_o.data_origin = ORG_IMM_RS1;
                ctrl_o.data_target = TGT_PC_4;
                ctrl_o.reg_w       = 1'b1;
                ctrl_o.r1_addr     = instr_i.r.rs1;
                ctrl_o.reg_addr    = instr_i.r.rd;
                imm_fmt_o          = IMM_I;
            end
            `OPC_BRANCH: begin
                ctrl_o.is_branch      = 1'b1;
                ctrl_o.is_conditional = 1'b1;
                ctrl_o.data_origin    = ORG_REGS;  // Compare rs1 against rs2
                ctrl_o.r1_addr        = instr_i.r.rs1;
                ctrl_o.r2_addr        = instr_i.r.rs2;
                ctrl_o.alu_op         = ALU_SUB;   // Zero test for EQ and NE
                imm_fmt_o             = IMM_B;
                case (instr_i.r.funct3)
                    `F3_BEQ:  ctrl_o.br_op = BR_EQ;
                    `F3_BNE:  ctrl_o.br_op = BR_NE;
                    `F3_BLT: begin
                        ctrl_o.alu_op = ALU_SLT;
                        ctrl_o.br_op  = BR_LT;
                    end
                    `F3_BGE: begin
                        ctrl_o.alu_op = ALU_SLT;
                        ctrl_o.br_op  = BR_GE;
                    end
                    `F3_BLTU: begin
                        ctrl_o.alu_op = ALU_SLTU;  // Unsigned compare
                        ctrl_o.br_op  = BR_LT;
                    end
                    `F3_BGEU: begin
                        ctrl_o.alu_op = ALU_SLTU;
                        ctrl_o.br_op  = BR_GE;
                    end
                    default: ctrl_o.br_op = BR_EQ;
                endcase
            end
            `OPC_LOAD: begin
                ctrl_o.is_load_store = 1'b1;
                ctrl_o.data_origin   = ORG_IMM_RS1;  // Address is rs1 plus offset
                ctrl_o.data_target   = TGT_MEM;
                ctrl_o.reg_w         = 1'b1;
                ctrl_o.r1_addr       = instr_i.r.rs1;
                ctrl_o.reg_addr      = instr_i.r.rd;
                imm_fmt_o            = IMM_I;
                case (instr_i.r.funct3)
                    `F3_LB:  ctrl_o.lis_op = LIS_LB;
                    `F3_LH:  ctrl_o.lis_op = LIS_LH;
                    `F3_LW:  ctrl_o.lis_op = LIS_LW;
                    `F3_LBU: ctrl_o.lis_op = LIS_LBU;
                    `F3_LHU: ctrl_o.lis_op = LIS_LHU;
                    default: ctrl_o.lis_op = LIS_LB;
                endcase
            end
            `OPC_STORE: begin
                ctrl_o.is_load_store = 1'b1;
                ctrl_o.mem_w         = 1'b1;
                ctrl_o.data_origin   = ORG_IMM_RS1;
                ctrl_o.r1_addr       = instr_i.r.rs1;  // Base address
                ctrl_o.r2_addr       = instr_i.r.rs2;  // Store data
                imm_fmt_o            = IMM_S;
                case (instr_i.r.funct3)
                    `F3_SB: begin
                        ctrl_o.lis_op         = LIS_SB;
                        ctrl_o.write_transfer = 4'b0001;
                    end
                    `F3_SH: begin
                        ctrl_o.lis_op         = LIS_SH;
                        ctrl_o.write_transfer = 4'b0011;
                    end
                    `F3_SW: begin
                        ctrl_o.lis_op         = LIS_SW;
                        ctrl_o.write_transfer = 4'b1111;
                    end
                    default: ctrl_o.write_transfer = '0;  // No bytes written
                endcase
            end
            `OPC_IMM: begin
                ctrl_o.alu_op      = alu_fn;  // No SUB in the immediate form
                ctrl_o.data_origin = ORG_IMM_RS1;
                ctrl_o.reg_w       = 1'b1;
                ctrl_o.r1_addr     = instr_i.r.rs1;
                ctrl_o.reg_addr    = instr_i.r.rd;
                imm_fmt_o          = IMM_I;
            end
            `OPC_ALU: begin
                if (instr_i.r.funct3 == `F3_ADD_SUB && instr_i.r.funct7[5]) begin
                    ctrl_o.alu_op = ALU_SUB;
                end else begin
                    ctrl_o.alu_op = alu_fn;
                end
                ctrl_o.reg_w    = 1'b1;
                ctrl_o.r1_addr  = instr_i.r.rs1;
                ctrl_o.r2_addr  = instr_i.r.rs2;
                ctrl_o.reg_addr = instr_i.r.rd;
            end
            default: begin
                // FENCE, SYSTEM and illegal words decode to nothing
                ctrl_o = '0;
            end
        endcase
    end

endmodule

//--- source/rv_decoder.sv
`include "rv_decoder_consts.svh"

module rv_decoder import rv_decoder_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  instr_u            instr_i,      // Held by the core during a stall
    output ctrl_t             ctrl_o,
    output logic [`XLEN-1:0]  imm_val_o,
    input  logic              mem_gnt_i,
    input  logic              mem_rvalid_i,
    input  logic              load_wait_i,
    output logic              mem_req_o,
    output logic              is_stall_o,
    output logic              load_wait_o
);

    imm_fmt_t imm_fmt;  // Format select from decode to immediate builder

    op_decode u_op_decode (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl_o),
        .imm_fmt_o (imm_fmt)
    );

    imm_gen u_imm_gen (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_val_o (imm_val_o)
    );

    // Stall sequencing driven by the decoded access type
    mem_access_fsm u_mem_access_fsm (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .is_load_store_i (ctrl_o.is_load_store),
        .mem_w_i         (ctrl_o.mem_w),
        .mem_gnt_i       (mem_gnt_i),
        .mem_rvalid_i    (mem_rvalid_i),
        .load_wait_i     (load_wait_i),
        .mem_req_o       (mem_req_o),
        .is_stall_o      (is_stall_o),
        .load_wait_o     (load_wait_o)
    );

endmodule

//--- source/rv_decoder_consts.svh
`ifndef RV_DECODER_CONSTS_SVH
`define RV_DECODER_CONSTS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define TRANSFER_W  4   // One enable per byte of a word

// Major opcodes, RV32I base set
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_IMM     7'b0010011
`define OPC_ALU     7'b0110011

// Branch funct3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// Load funct3
`define F3_LB       3'b000
`define F3_LH       3'b001
`define F3_LW       3'b010
`define F3_LBU      3'b100
`define F3_LHU      3'b101

// Store funct3
`define F3_SB       3'b000
`define F3_SH       3'b001
`define F3_SW       3'b010

// ALU funct3, shared by the register and immediate forms
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`endif

//--- source/rv_decoder_pkg.sv
`include "rv_decoder_consts.svh"

package rv_decoder_pkg;

    // Operation codes seen by the execution unit
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        LIS_LB, LIS_LH, LIS_LW, LIS_LBU, LIS_LHU,  // Loads
        LIS_SB, LIS_SH, LIS_SW                     // Stores
    } lis_op_t;

    typedef enum logic [1:0] {BR_EQ, BR_NE, BR_LT, BR_GE} br_op_t;

    typedef enum logic [1:0] {
        ORG_REGS,     // rs1 and rs2
        ORG_IMM_RS1,  // Immediate with rs1
        ORG_IMM_PC    // Immediate with the PC
    } data_origin_t;

    typedef enum logic [1:0] {
        TGT_ALU,   // ALU result to rd
        TGT_MEM,   // Loaded word to rd
        TGT_PC_4   // Return address to rd
    } data_target_t;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_t;

    // One instruction word, one view per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;   // Sits where the S format keeps imm[0]
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

    // Control word handed to the execution unit
    typedef struct packed {
        alu_op_t                 alu_op;
        lis_op_t                 lis_op;
        br_op_t                  br_op;
        data_origin_t            data_origin;
        data_target_t            data_target;
        logic                    is_load_store;
        logic                    is_branch;       // JAL, JALR and conditional branches
        logic                    is_conditional;
        logic                    mem_w;
        logic                    reg_w;
        logic [`REG_ADDR_W-1:0]  r1_addr;
        logic [`REG_ADDR_W-1:0]  r2_addr;
        logic [`REG_ADDR_W-1:0]  reg_addr;        // rd
        logic [`TRANSFER_W-1:0]  write_transfer;  // Byte enables for stores
    } ctrl_t;

endpackage

//--- testbench/tb_rv_decoder.sv
`include "rv_decoder_consts.svh"

module tb_rv_decoder import rv_decoder_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 8;
    localparam int RST_CYCLES  = 5;
    localparam int NUM_TESTS   = 300;
    localparam int MAX_DLY     = 8;   // Grant plus completion delay per access
    localparam int WATCHDOG_NS = (NUM_TESTS * (MAX_DLY + 4) + RST_CYCLES + 2) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'hb09aa394;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;

    logic              clk = 1'b0;
    logic              rst_n;
    instr_u            instr;
    ctrl_t             ctrl;
    logic [`XLEN-1:0]  imm_val;
    logic              mem_gnt;
    logic              mem_rvalid;
    logic              load_wait_in;   // Completion flag for loads
    logic              mem_req;
    logic              is_stall;
    logic              load_wait_out;

    // Expected values, rebuilt every cycle
    ctrl_t             exp_ctrl;
    logic [`XLEN-1:0]  exp_imm;
    logic [2:0]        exp_mem;        // {req, stall, load wait}
    logic              mem_state = 1'b0;  // Model of the data wait phase
    logic              mem_next = 1'b0;
    logic              mem_done;
    string             cur_test = "reset";
    int                ctrl_errs = 0;
    int                imm_errs = 0;
    int                mem_errs = 0;

    rv_decoder u_rv_decoder (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .instr_i      (instr),
        .ctrl_o       (ctrl),
        .imm_val_o    (imm_val),
        .mem_gnt_i    (mem_gnt),
        .mem_rvalid_i (mem_rvalid),
        .load_wait_i  (load_wait_in),
        .mem_req_o    (mem_req),
        .is_stall_o   (is_stall),
        .load_wait_o  (load_wait_out)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // funct7 bit 5 only turns ADD into SUB in the register form
    function automatic alu_op_t ref_alu(input logic [2:0] f3, input logic alt, input logic is_reg);
        case (f3)
            `F3_ADD_SUB: return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            `F3_SLL:     return ALU_SLL;
            `F3_SLT:     return ALU_SLT;
            `F3_SLTU:    return ALU_SLTU;
            `F3_XOR:     return ALU_XOR;
            `F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      return ALU_OR;
            default:     return ALU_AND;
        endcase
    endfunction

    // Expected control word straight from the RV32I encoding
    function automatic ctrl_t ref_ctrl(input logic [31:0] w);
        ctrl_t      c;
        logic [2:0] f3;
        c  = '0;
        f3 = w[14:12];
        case (w[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                c.data_origin = (w[6:0] == `OPC_LUI) ? ORG_IMM_RS1 : ORG_IMM_PC;
                c.reg_w       = 1'b1;
                c.reg_addr    = w[11:7];
            end
            `OPC_JAL, `OPC_JALR: begin
                c.is_branch   = 1'b1;
                c.data_target = TGT_PC_4;
                c.reg_w       = 1'b1;
                c.reg_addr    = w[11:7];
                c.data_origin = (w[6:0] == `OPC_JALR) ? ORG_IMM_RS1 : ORG_IMM_PC;
                c.r1_addr     = (w[6:0] == `OPC_JALR) ? w[19:15] : 5'd0;
            end
            `OPC_BRANCH: begin
                c.is_branch      = 1'b1;
                c.is_conditional = 1'b1;
                c.r1_addr        = w[19:15];
                c.r2_addr        = w[24:20];
                c.br_op          = br_op_t'({f3[2], f3[0]});  // Bit 0 negates the test
                c.alu_op         = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
            end
            `OPC_LOAD: begin
                c.is_load_store = 1'b1;
                c.data_origin   = ORG_IMM_RS1;
                c.data_target   = TGT_MEM;
                c.reg_w         = 1'b1;
                c.r1_addr       = w[19:15];
                c.reg_addr      = w[11:7];
                c.lis_op        = lis_op_t'(f3[2] ? 3'd3 + {1'b0, f3[1:0]} : {1'b0, f3[1:0]});
            end
            `OPC_STORE: begin
                c.is_load_store  = 1'b1;
                c.mem_w          = 1'b1;
                c.data_origin    = ORG_IMM_RS1;
                c.r1_addr        = w[19:15];
                c.r2_addr        = w[24:20];
                c.lis_op         = lis_op_t'(3'd5 + {1'b0, f3[1:0]});
                c.write_transfer = (f3[1:0] == 2'd0) ? 4'b0001 :
                                   (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
            end
            `OPC_IMM: begin
                c.alu_op      = ref_alu(f3, w[30], 1'b0);
                c.data_origin = ORG_IMM_RS1;
                c.reg_w       = 1'b1;
                c.r1_addr     = w[19:15];
                c.reg_addr    = w[11:7];
            end
            `OPC_ALU: begin
                c.alu_op   = ref_alu(f3, w[30], 1'b1);
                c.reg_w    = 1'b1;
                c.r1_addr  = w[19:15];
                c.r2_addr  = w[24:20];
                c.reg_addr = w[11:7];
            end
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        case (w[6:0])
            `OPC_LUI, `OPC_AUIPC:          return {w[31:12], 12'b0};
            `OPC_JAL:                      return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            `OPC_JALR, `OPC_LOAD, `OPC_IMM: return {{20{w[31]}}, w[31:20]};
            `OPC_STORE:                    return {{20{w[31]}}, w[31:25], w[11:7]};
            `OPC_BRANCH:                   return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            default:                       return '0;
        endcase
    endfunction

    function automatic logic known_opcode(input logic [6:0] op);
        return op inside {`OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
                          `OPC_LOAD, `OPC_STORE, `OPC_IMM, `OPC_ALU};
    endfunction

    // Compare at the falling edge where every output has settled
    always @(negedge clk) begin
        exp_ctrl = ref_ctrl(instr);
        exp_imm  = ref_imm(instr);
        exp_mem  = 3'b000;
        mem_next = mem_state;
        if (!rst_n) begin
            mem_next = 1'b0;             // Quiet in reset
        end else if (!mem_state) begin
            if (exp_ctrl.is_load_store) begin
                exp_mem = 3'b110;        // Request and stall until granted
                if (mem_gnt) mem_next = 1'b1;
            end
        end else begin
            mem_done = exp_ctrl.mem_w ? mem_rvalid : load_wait_in;
            if (mem_done) mem_next = 1'b0;
            else exp_mem = {2'b01, !exp_ctrl.mem_w};
        end
        if (ctrl !== exp_ctrl) begin
            ctrl_errs++;
            $display("FAILED %s: ctrl_o expected %h actual %h", cur_test, exp_ctrl, ctrl);
        end
        if (imm_val !== exp_imm) begin
            imm_errs++;
            $display("FAILED %s: imm_val_o expected %h actual %h", cur_test, exp_imm, imm_val);
        end
        if ({mem_req, is_stall, load_wait_out} !== exp_mem) begin
            mem_errs++;
            $display("FAILED %s: req/stall/load_wait expected %b actual %b", cur_test,
                     exp_mem, {mem_req, is_stall, load_wait_out});
        end
    end

    always @(posedge clk) mem_state <= mem_next;

    // Called at a rising edge, returns at the edge where the word may change
    task automatic apply_instr(input logic [31:0] w, input string name);
        int   gnt_dly;
        int   data_dly;
        logic is_mem;
        logic is_store;
        is_store = (w[6:0] == `OPC_STORE);
        is_mem   = (w[6:0] == `OPC_LOAD) || is_store;
        cur_test = name;
        instr   <= w;
        if (!is_mem) begin
            mem_gnt      <= 1'($urandom_range(1, 0));  // Noise, must be ignored
            mem_rvalid   <= 1'($urandom_range(1, 0));
            load_wait_in <= 1'($urandom_range(1, 0));
            @(posedge clk);
        end else begin
            gnt_dly  = $urandom_range(MAX_DLY / 2, 0);
            data_dly = $urandom_range(MAX_DLY / 2, 0);
            // Both completion flags toggle freely until the grant is taken
            for (int c = 0; c <= gnt_dly; c++) begin
                mem_gnt      <= (c == gnt_dly);
                mem_rvalid   <= 1'($urandom_range(1, 0));
                load_wait_in <= 1'($urandom_range(1, 0));
                @(posedge clk);
            end
            for (int c = 0; c <= data_dly; c++) begin
                mem_gnt <= 1'b0;
                if (is_store) begin
                    mem_rvalid   <= (c == data_dly);
                    load_wait_in <= 1'($urandom_range(1, 0));  // Not the flag of a store
                end else begin
                    mem_rvalid   <= 1'($urandom_range(1, 0));  // Not the flag of a load
                    load_wait_in <= (c == data_dly);
                end
                if (c < data_dly) @(posedge clk);
            end
            @(negedge clk);
            while (is_stall) @(negedge clk);  // Stall drops in the completion cycle
            @(posedge clk);
            mem_rvalid   <= 1'b0;
            load_wait_in <= 1'b0;
        end
    endtask

    initial begin
        int          grp;
        int          sel;
        logic [31:0] w;
        string       name;
        void'($urandom(SEED));
        rst_n        <= 1'b0;
        instr        <= {17'h0, `F3_LW, 5'd1, `OPC_LOAD};  // A load that reset must hold off
        mem_gnt      <= 1'b1;
        mem_rvalid   <= 1'b0;
        load_wait_in <= 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            grp = $urandom_range(4, 0);
            w   = $urandom;
            case (grp)
                0: begin
                    w[6:0] = $urandom_range(1, 0) ? `OPC_ALU : `OPC_IMM;
                    name   = "alu_ops";
                end
                1: begin
                    sel    = $urandom_range(3, 0);
                    w[6:0] = (sel == 0) ? `OPC_LUI : (sel == 1) ? `OPC_AUIPC :
                             (sel == 2) ? `OPC_JAL : `OPC_JALR;
                    name   = "upper_and_jump";
                end
                2: begin
                    sel      = $urandom_range(5, 0);
                    w[6:0]   = `OPC_BRANCH;
                    w[14:12] = (sel < 2) ? sel[2:0] : 3'(sel + 2);  // Skips 010 and 011
                    name     = "branch";
                end
                3: begin
                    if ($urandom_range(1, 0)) begin
                        sel      = $urandom_range(4, 0);
                        w[6:0]   = `OPC_LOAD;
                        w[14:12] = (sel < 3) ? sel[2:0] : 3'(sel + 1);
                    end else begin
                        w[6:0]   = `OPC_STORE;
                        w[14:12] = 3'($urandom_range(2, 0));
                    end
                    name = "load_store";
                end
                default: begin
                    sel = $urandom_range(2, 0);
                    if (sel == 0) w[6:0] = OPC_SYSTEM;
                    else if (sel == 1) w[6:0] = OPC_FENCE;
                    else while (known_opcode(w[6:0])) w[6:0] = 7'($urandom);
                    name = "unused_opcode";
                end
            endcase
            apply_instr(w, name);
        end
        @(negedge clk);  // Last word gets its compare
        $display("Error counts: ctrl %0d, imm %0d, memory %0d", ctrl_errs, imm_errs, mem_errs);
        if (ctrl_errs + imm_errs + mem_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule
